/* Makefile */
# verilator flow for the midi synth

TOP = synth_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o synth_sim
	./obj_dir/synth_sim | tee sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/midi_decoder.sv */
// ------------------------------------------------
// midi byte parser
// running status, real-time bytes pass through,
// one message strobe per complete channel message
// ------------------------------------------------
`default_nettype none

module midi_decoder import synth_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       rx_vld,
    input  wire logic [7:0] rx_byte,
    output logic            msg_vld,
    output midi_msg_t       msg
);

    // running status
    logic       rs_vld_q;
    midi_op_e   rs_op_q;
    logic [3:0] rs_ch_q;
    // set when only one data byte follows
    logic       rs_one_q;
    // high once the first data byte is held
    logic       cnt_q;
    logic [6:0] data0_q;

    logic is_status;
    logic is_sys;
    logic is_rt;
    logic take_data;
    logic emit;

    always_comb begin
        is_status = rx_byte[7];
        is_sys    = rx_byte[7:4] == 4'hf;
        // f8 and up
        is_rt     = rx_byte[7:3] == 5'b11111;
        take_data = rx_vld && !is_status && rs_vld_q;
        emit      = take_data && (cnt_q || rs_one_q);
    end

    // ------------------------------------------------
    // status tracking
    // ------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rs_vld_q <= 1'b0;
            rs_op_q  <= op_note_off;
            rs_ch_q  <= '0;
            rs_one_q <= 1'b0;
            cnt_q    <= 1'b0;
            msg_vld  <= 1'b0;
        end else begin
            msg_vld <= emit;
            if (rx_vld && is_sys) begin
                // sysex, song position etc. cancel running status
                if (!is_rt) begin
                    rs_vld_q <= 1'b0;
                    cnt_q    <= 1'b0;
                end
            end else if (rx_vld && is_status) begin
                rs_vld_q <= 1'b1;
                rs_op_q  <= midi_op_e'(rx_byte[6:4]);
                rs_ch_q  <= rx_byte[3:0];
                rs_one_q <= rx_byte[6:4] == 3'd4 || rx_byte[6:4] == 3'd5;
                cnt_q    <= 1'b0;
            end else if (take_data) begin
                // back to first byte after emit, running status stays
                cnt_q <= !emit;
            end
        end
    end

    // ------------------------------------------------
    // data bytes and message assembly
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (take_data && !cnt_q) begin
            data0_q <= rx_byte[6:0];
        end
        if (emit) begin
            msg.op    <= rs_op_q;
            msg.ch    <= rs_ch_q;
            // single-byte messages carry data0 only
            msg.data0 <= cnt_q ? data0_q : rx_byte[6:0];
            msg.data1 <= cnt_q ? rx_byte[6:0] : 7'd0;
        end
    end

endmodule

`default_nettype wire

/* rtl/pulse_voice.sv */
// ------------------------------------------------
// square-wave voice
// monophonic, note on/off and cc10 pan on one channel,
// one stereo sample per tick
// ------------------------------------------------
`default_nettype none

module pulse_voice import synth_pkg::*; #(
    parameter logic [3:0] midi_ch = 4'd0
) (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      msg_vld,
    input  wire midi_msg_t msg,
    input  wire logic      smpl_tick,
    output logic           smpl_vld,
    output stereo_smpl_t   smpl
);

    logic [6:0]  note_q;
    // velocity * 1024
    logic [16:0] amp_q;
    logic [15:0] step_q;
    logic [6:0]  pan_q;
    logic [15:0] phase_q;

    logic              for_us;
    logic              key_on;
    logic              key_off;
    logic              pan_set;
    logic [15:0]       phase_nxt;
    logic [23:0]       prod_l;
    logic [23:0]       prod_r;
    logic [smpl_w-1:0] mag_l;
    logic [smpl_w-1:0] mag_r;

    // ------------------------------------------------
    // message decode
    // ------------------------------------------------
    always_comb begin
        for_us  = msg_vld && (msg.ch == midi_ch);
        key_on  = for_us && msg.op == op_note_on && msg.data1 != 7'd0;
        // velocity 0 note-on counts as note-off
        key_off = for_us && msg.data0 == note_q &&
                  (msg.op == op_note_off || (msg.op == op_note_on && msg.data1 == 7'd0));
        pan_set = for_us && msg.op == op_ctrl_chg && msg.data0 == 7'd10;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            note_q <= '0;
            amp_q  <= '0;
            step_q <= '0;
            pan_q  <= 7'd64;
        end else begin
            if (key_on) begin
                note_q <= msg.data0;
                amp_q  <= {msg.data1, 10'd0};
                step_q <= note_step(msg.data0);
            end else if (key_off) begin
                amp_q <= '0;
            end
            if (pan_set) begin
                pan_q <= msg.data1;
            end
        end
    end

    // ------------------------------------------------
    // sample generation
    // ------------------------------------------------
    always_comb begin
        phase_nxt = phase_q + step_q;
        // magnitudes before the sign, so truncation is toward zero
        prod_l    = 24'(amp_q) * 24'(7'd127 - pan_q);
        prod_r    = 24'(amp_q) * 24'(pan_q);
        mag_l     = {1'b0, prod_l[23:7]};
        mag_r     = {1'b0, prod_r[23:7]};
    end

    // sign taken from the advanced phase
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q  <= '0;
            smpl_vld <= 1'b0;
            smpl     <= '0;
        end else begin
            smpl_vld <= smpl_tick;
            if (smpl_tick) begin
                phase_q    <= phase_nxt;
                smpl.left  <= phase_nxt[15] ? -mag_l : mag_l;
                smpl.right <= phase_nxt[15] ? -mag_r : mag_r;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/sample_tick_gen.sv */
// ------------------------------------------------
// sample rate tick
// one strobe every smpl_div clocks
// ------------------------------------------------
`default_nettype none

module sample_tick_gen #(
    parameter int smpl_div = 40
) (
    input  wire logic clk,
    input  wire logic arst_n,
    output logic      smpl_tick
);

    localparam int cnt_w = $clog2(smpl_div);
    localparam logic [cnt_w-1:0] reload = cnt_w'(smpl_div - 1);

    logic [cnt_w-1:0] cnt_q;

    // down-counter, strobe on wrap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q     <= reload;
            smpl_tick <= 1'b0;
        end else begin
            smpl_tick <= cnt_q == '0;
            cnt_q     <= (cnt_q == '0) ? reload : cnt_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/stereo_dac_output.sv */
// ------------------------------------------------
// stereo sigma-delta dac
// first-order modulator per channel, 1-bit outputs
// ------------------------------------------------
`default_nettype none

module stereo_dac_output import synth_pkg::*; (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic         smpl_vld,
    input  wire stereo_smpl_t smpl,
    output logic              dac_out_l,
    output logic              dac_out_r
);

    // index 0 left, 1 right
    logic [1:0][smpl_w-1:0] lvl_in;
    logic [1:0][smpl_w-1:0] lvl_q;
    logic [1:0][smpl_w-1:0] acc_q;
    logic [1:0][smpl_w:0]   sum;
    logic [1:0]             bit_q;

    // ------------------------------------------------
    // offset binary, sample + 2^17
    // ------------------------------------------------
    always_comb begin
        lvl_in[0] = {~smpl.left[smpl_w-1], smpl.left[smpl_w-2:0]};
        lvl_in[1] = {~smpl.right[smpl_w-1], smpl.right[smpl_w-2:0]};
        for (int ch = 0; ch < 2; ch++) begin
            sum[ch] = {1'b0, acc_q[ch]} + {1'b0, lvl_q[ch]};
        end
    end

    // ------------------------------------------------
    // modulators
    // ------------------------------------------------
    // level stays 0 until the first sample, so output idles low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lvl_q <= '0;
            acc_q <= '0;
            bit_q <= '0;
        end else begin
            if (smpl_vld) begin
                lvl_q <= lvl_in;
            end
            for (int ch = 0; ch < 2; ch++) begin
                // carry out of 2^18 is the output bit
                acc_q[ch] <= sum[ch][smpl_w-1:0];
                bit_q[ch] <= sum[ch][smpl_w];
            end
        end
    end

    assign dac_out_l = bit_q[0];
    assign dac_out_r = bit_q[1];

endmodule

`default_nettype wire

/* rtl/synth_pkg.sv */
// ------------------------------------------------
// synth package
// message and sample types shared by the voice path,
// plus the note to phase increment table
// ------------------------------------------------
`default_nettype none

package synth_pkg;

    // sample width, signed
    localparam int smpl_w = 18;

    // opcode is the upper status nibble minus 8
    typedef enum logic [2:0] {
        op_note_off   = 3'd0,
        op_note_on    = 3'd1,
        op_poly_at    = 3'd2,
        op_ctrl_chg   = 3'd3,
        op_prog_chg   = 3'd4,
        op_chan_at    = 3'd5,
        op_pitch_bend = 3'd6
    } midi_op_e;

    // one complete channel message, 21 bits
    typedef struct packed {
        midi_op_e   op;
        logic [3:0] ch;
        logic [6:0] data0;
        logic [6:0] data1;
    } midi_msg_t;

    typedef struct packed {
        logic signed [smpl_w-1:0] left;
        logic signed [smpl_w-1:0] right;
    } stereo_smpl_t;

    // ------------------------------------------------
    // phase step per sample for a 16-bit accumulator
    // table holds notes 108..119 at 48 kHz,
    // lower octaves shift right, top octave shifts left
    // ------------------------------------------------
    function automatic logic [15:0] note_step(input logic [6:0] note);
        logic [3:0]  octave;
        logic [3:0]  idx;
        logic [15:0] base;
        octave = 4'(note / 7'd12);
        idx    = 4'(note % 7'd12);
        case (idx)
            4'd0:    base = 16'd5715;
            4'd1:    base = 16'd6055;
            4'd2:    base = 16'd6415;
            4'd3:    base = 16'd6797;
            4'd4:    base = 16'd7201;
            4'd5:    base = 16'd7629;
            4'd6:    base = 16'd8083;
            4'd7:    base = 16'd8563;
            4'd8:    base = 16'd9072;
            4'd9:    base = 16'd9612;
            4'd10:   base = 16'd10183;
            default: base = 16'd10789;
        endcase
        // notes 120..127 sit one octave above the table
        if (octave == 4'd10) begin
            return base << 1;
        end
        return base >> (4'd9 - octave);
    endfunction

endpackage

`default_nettype wire

/* rtl/synth_top.sv */
// ------------------------------------------------
// midi pulse synth top
// uart -> midi decode -> voice -> sigma-delta dac
// ------------------------------------------------
`default_nettype none

module synth_top import synth_pkg::*; #(
    parameter int         clk_freq  = 1_600_000,
    parameter int         baud_rate = 100_000,
    parameter int         smpl_div  = 40,
    parameter logic [3:0] midi_ch   = 4'd0
) (
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    rx,
    output logic         dac_out_l,
    output logic         dac_out_r,
    output logic         smpl_vld,
    output stereo_smpl_t smpl
);

    logic       rx_vld;
    logic [7:0] rx_byte;
    logic       msg_vld;
    midi_msg_t  msg;
    logic       smpl_tick;

    uart_rx #(
        .clks_per_bit(clk_freq / baud_rate)
    ) u_uart_rx (
        .clk    (clk    ),
        .arst_n (arst_n ),
        .rx     (rx     ),
        .rx_vld (rx_vld ),
        .rx_byte(rx_byte)
    );

    midi_decoder u_midi_decoder (
        .clk    (clk    ),
        .arst_n (arst_n ),
        .rx_vld (rx_vld ),
        .rx_byte(rx_byte),
        .msg_vld(msg_vld),
        .msg    (msg    )
    );

    sample_tick_gen #(
        .smpl_div(smpl_div)
    ) u_sample_tick_gen (
        .clk      (clk      ),
        .arst_n   (arst_n   ),
        .smpl_tick(smpl_tick)
    );

    pulse_voice #(
        .midi_ch(midi_ch)
    ) u_pulse_voice (
        .clk      (clk      ),
        .arst_n   (arst_n   ),
        .msg_vld  (msg_vld  ),
        .msg      (msg      ),
        .smpl_tick(smpl_tick),
        .smpl_vld (smpl_vld ),
        .smpl     (smpl     )
    );

    stereo_dac_output u_stereo_dac_output (
        .clk      (clk      ),
        .arst_n   (arst_n   ),
        .smpl_vld (smpl_vld ),
        .smpl     (smpl     ),
        .dac_out_l(dac_out_l),
        .dac_out_r(dac_out_r)
    );

endmodule

`default_nettype wire

/* rtl/uart_rx.sv */
// ------------------------------------------------
// uart receiver, 8N1
// mid-bit sampling, one-cycle strobe per good byte
// ------------------------------------------------
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = 16
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       rx,
    output logic            rx_vld,
    output logic [7:0]      rx_byte
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e        state_q;
    logic [1:0]       sync_q;
    logic [cnt_w-1:0] cnt_q;
    logic [2:0]       bit_q;
    logic [7:0]       shift_q;
    logic             rx_s;

    // ------------------------------------------------
    // input synchronizer
    // ------------------------------------------------
    // line idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx};
        end
    end

    assign rx_s = sync_q[1];

    // ------------------------------------------------
    // receive fsm
    // ------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
            bit_q   <= '0;
            rx_vld  <= 1'b0;
        end else begin
            rx_vld <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (!rx_s) begin
                        state_q <= st_start;
                        cnt_q   <= '0;
                    end
                end
                st_start: begin
                    // start bit must still be low at mid-bit
                    if (cnt_q == half_cnt) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rx_s ? st_idle : st_data;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                st_data: begin
                    if (cnt_q == last_cnt) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= st_stop;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    // framing error drops the byte
                    if (cnt_q == last_cnt) begin
                        state_q <= st_idle;
                        rx_vld  <= rx_s;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state_q == st_data && cnt_q == last_cnt) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

endmodule

`default_nettype wire

/* tb/synth_checker.sv */
// ------------------------------------------------
// synth checker
// strobe width, sample period and reset values
// ------------------------------------------------
`default_nettype none

module synth_checker import synth_pkg::*; #(
    parameter int smpl_div = 40
) (
    input wire logic         clk,
    input wire logic         arst_n,
    input wire logic         rx_vld,
    input wire logic         msg_vld,
    input wire logic         smpl_tick,
    input wire logic         smpl_vld,
    input wire logic         dac_out_l,
    input wire logic         dac_out_r,
    input wire stereo_smpl_t smpl
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // one-cycle strobes
    a_strobes: assert property (@(posedge clk) disable iff (!arst_n)
        (rx_vld |=> !rx_vld) and (msg_vld |=> !msg_vld) and
        (smpl_tick |=> !smpl_tick) and (smpl_vld |=> !smpl_vld))
        else begin
            assert_fails++;
            $error("strobe held longer than one cycle");
        end

    a_period: assert property (@(posedge clk) disable iff (!arst_n)
        smpl_vld |=> !smpl_vld [* smpl_div - 1] ##1 smpl_vld)
        else begin
            assert_fails++;
            $error("sample strobe period broken");
        end

    a_reset: assert property (@(posedge clk)
        !arst_n |-> !rx_vld && !msg_vld && !smpl_tick && !smpl_vld &&
                    !dac_out_l && !dac_out_r && smpl == '0)
        else begin
            assert_fails++;
            $error("output active during reset");
        end

endmodule

bind synth_top synth_checker #(.smpl_div(smpl_div)) u_synth_checker (.*);

`default_nettype wire

/* tb/synth_monitor.sv */
// ------------------------------------------------
// synth monitor
// compares samples and dac bit density with the model
// ------------------------------------------------
`default_nettype none

module synth_monitor import synth_pkg::*; (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic         smpl_vld,
    input  wire stereo_smpl_t smpl,
    input  wire logic         dac_out_l,
    input  wire logic         dac_out_r,
    input  wire logic [16:0]  exp_amp,
    input  wire logic [15:0]  exp_step,
    input  wire logic [6:0]   exp_pan,
    input  var int            test_id,
    output int                smpl_errs,
    output int                dac_errs
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam longint full = 64'd1 << 18;

    logic [15:0] phase_m;
    // offset levels, running input sums and ones counts
    longint      lvl_m [2];
    longint      sum_m [2];
    longint      ones_m [2];

    function automatic string test_name(input int id);
        case (id)
            0:       return "idle";
            1:       return "note_on";
            2:       return "note_off";
            3:       return "mixed";
            default: return "pan";
        endcase
    endfunction

    // ------------------------------------------------
    // sample compare
    // ------------------------------------------------
    always @(posedge clk or negedge arst_n) begin
        int mag_l;
        int mag_r;
        int e_l;
        int e_r;
        if (!arst_n) begin
            phase_m   <= '0;
            smpl_errs = 0;
        end else if (smpl_vld) begin
            mag_l = (int'(exp_amp) * (127 - int'(exp_pan))) / 128;
            mag_r = (int'(exp_amp) * int'(exp_pan)) / 128;
            // square wave sign from the advanced phase
            if (((phase_m + exp_step) & 16'h8000) != 0) begin
                e_l = -mag_l;
                e_r = -mag_r;
            end else begin
                e_l = mag_l;
                e_r = mag_r;
            end
            phase_m <= phase_m + exp_step;
            if (int'(smpl.left) != e_l) begin
                $display("MISMATCH %s left expected=%0d actual=%0d",
                         test_name(test_id), e_l, smpl.left);
                smpl_errs = smpl_errs + 1;
            end
            if (int'(smpl.right) != e_r) begin
                $display("MISMATCH %s right expected=%0d actual=%0d",
                         test_name(test_id), e_r, smpl.right);
                smpl_errs = smpl_errs + 1;
            end
        end
    end

    // ------------------------------------------------
    // dac density, ones count is the input sum over 2^18
    // ------------------------------------------------
    always @(posedge clk or negedge arst_n) begin
        longint exp_ones;
        if (!arst_n) begin
            dac_errs = 0;
            for (int c = 0; c < 2; c++) begin
                lvl_m[c]  = 0;
                sum_m[c]  = 0;
                ones_m[c] = 0;
            end
        end else begin
            ones_m[0] = ones_m[0] + longint'(dac_out_l);
            ones_m[1] = ones_m[1] + longint'(dac_out_r);
            for (int c = 0; c < 2; c++) begin
                // sum never goes negative, so floor division
                exp_ones = sum_m[c] / full;
                if (ones_m[c] != exp_ones) begin
                    $display("MISMATCH %s dac channel %0d ones expected=%0d actual=%0d",
                             test_name(test_id), c, exp_ones, ones_m[c]);
                    dac_errs = dac_errs + 1;
                end
                sum_m[c] = sum_m[c] + lvl_m[c];
            end
            if (smpl_vld) begin
                lvl_m[0] = longint'(smpl.left) + full / 2;
                lvl_m[1] = longint'(smpl.right) + full / 2;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/synth_tb.sv */
// ------------------------------------------------
// synth testbench
// midi bytes over uart, reference voice model,
// timeout and closing summary
// ------------------------------------------------
`default_nettype none

module synth_tb import synth_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clks_per_bit = 16;
    localparam int smpl_div     = 40;
    localparam int n_idle       = 20;
    localparam int n_note       = 24;
    localparam int n_off        = 8;
    localparam int n_mixed      = 60;
    localparam int n_pan        = 16;
    // worst case per message: 6 bytes, 4 gap samples plus alignment
    localparam int n_msgs       = n_note + 3 * n_off + n_mixed + 2 * n_pan;
    localparam int max_cycles   =
        3 * (n_msgs * (6 * 10 * clks_per_bit + 6 * smpl_div) + (n_idle + 8) * smpl_div) / 2;

    logic         clk;
    logic         arst_n;
    logic         rx;
    logic         dac_out_l;
    logic         dac_out_r;
    logic         smpl_vld;
    stereo_smpl_t smpl;

    // model voice state, read by the monitor
    logic [16:0]  exp_amp;
    logic [15:0]  exp_step;
    logic [6:0]   exp_pan;
    logic [6:0]   exp_note;
    int           test_id;
    int           smpl_errs;
    int           dac_errs;
    int           cycles;

    // model decoder state
    logic         rs_vld;
    logic [2:0]   rs_op;
    logic [3:0]   rs_ch;
    logic         have0;
    logic [6:0]   d0_hold;
    logic [15:0]  lfsr;

    synth_top #(
        .clk_freq (1_600_000),
        .baud_rate(100_000),
        .smpl_div (smpl_div),
        .midi_ch  (4'd3)
    ) u_synth_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .dac_out_l(dac_out_l),
        .dac_out_r(dac_out_r),
        .smpl_vld (smpl_vld),
        .smpl     (smpl)
    );

    synth_monitor u_synth_monitor (
        .clk      (clk),
        .arst_n   (arst_n),
        .smpl_vld (smpl_vld),
        .smpl     (smpl),
        .dac_out_l(dac_out_l),
        .dac_out_r(dac_out_r),
        .exp_amp  (exp_amp),
        .exp_step (exp_step),
        .exp_pan  (exp_pan),
        .test_id  (test_id),
        .smpl_errs(smpl_errs),
        .dac_errs (dac_errs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------
    // random bits, galois lfsr x^16+x^14+x^13+x^11+1
    // ------------------------------------------------
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // increments for notes 108..119, one octave per shift
    function automatic logic [15:0] pitch_incr(input logic [6:0] note);
        logic [15:0] tbl [12];
        int          oct;
        tbl = '{16'd5715, 16'd6055, 16'd6415, 16'd6797, 16'd7201, 16'd7629,
                16'd8083, 16'd8563, 16'd9072, 16'd9612, 16'd10183, 16'd10789};
        oct = int'(note) / 12;
        if (oct == 10) begin
            return tbl[int'(note) % 12] << 1;
        end
        return tbl[int'(note) % 12] >> (9 - oct);
    endfunction

    // voice reaction to one complete message
    task automatic apply_msg(input logic [2:0] op, input logic [3:0] ch,
                             input logic [6:0] d0, input logic [6:0] d1);
        if (ch == 4'd3) begin
            if (op == 3'd1 && d1 != 7'd0) begin
                exp_note = d0;
                exp_amp  = {d1, 10'd0};
                exp_step = pitch_incr(d0);
            end else if (d0 == exp_note && (op == 3'd0 || (op == 3'd1 && d1 == 7'd0))) begin
                exp_amp = '0;
            end
            if (op == 3'd3 && d0 == 7'd10) begin
                exp_pan = d1;
            end
        end
    endtask

    // model parser, running status kept across real-time bytes
    task automatic model_byte(input logic [7:0] b);
        logic one;
        one = rs_op == 3'd4 || rs_op == 3'd5;
        if (b >= 8'hf8) begin
            return;
        end else if (b >= 8'hf0) begin
            rs_vld = 1'b0;
            have0  = 1'b0;
        end else if (b[7]) begin
            rs_vld = 1'b1;
            rs_op  = b[6:4];
            rs_ch  = b[3:0];
            have0  = 1'b0;
        end else if (rs_vld) begin
            if (!have0 && !one) begin
                d0_hold = b[6:0];
                have0   = 1'b1;
            end else begin
                apply_msg(rs_op, rs_ch, have0 ? d0_hold : b[6:0], have0 ? b[6:0] : 7'd0);
                have0 = 1'b0;
            end
        end
    endtask

    // 8N1 on falling edges, model sees the byte at the stop bit end
    task automatic send_byte(input logic [7:0] b);
        rx = 1'b0;
        repeat (clks_per_bit) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        rx = 1'b1;
        repeat (clks_per_bit) @(negedge clk);
        model_byte(b);
    endtask

    // random gap, then start 20 clocks after a sample so that
    // every message lands far from a tick
    task automatic gap_align();
        int n;
        n = int'(take_bits(2));
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            while (!smpl_vld) @(posedge clk);
        end
        repeat (20) @(negedge clk);
    endtask

    task automatic send_msg(input logic [7:0] s, input logic [6:0] d0, input logic [6:0] d1);
        gap_align();
        send_byte(s);
        send_byte({1'b0, d0});
        send_byte({1'b0, d1});
    endtask

    // a mixed message, maybe running status, real-time byte or system byte
    task automatic send_mixed();
        logic [2:0] op;
        logic [3:0] ch;
        int         nd;
        op = 3'(take_bits(3));
        ch = (take_bits(1) != 16'd0) ? 4'd3 : 4'(take_bits(4));
        gap_align();
        if (op == 3'd7) begin
            send_byte(8'hf6);
            op = 3'd1;
        end
        if (take_bits(2) != 16'd0) begin
            send_byte({1'b1, op, ch});
        end
        nd = (op == 3'd4 || op == 3'd5) ? 1 : 2;
        for (int i = 0; i < nd; i++) begin
            if (take_bits(2) == 16'd0) begin
                send_byte(8'hf8);
            end
            send_byte({1'b0, (op == 3'd3 && i == 0 && take_bits(1) != 16'd0) ?
                             7'd10 : 7'(take_bits(7))});
        end
    endtask

    // ------------------------------------------------
    // timeout
    // ------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [6:0] n;
        lfsr     = 16'd24;
        rx       = 1'b1;
        arst_n   = 1'b0;
        cycles   = 0;
        test_id  = 0;
        exp_amp  = '0;
        exp_step = '0;
        exp_pan  = 7'd64;
        exp_note = '0;
        rs_vld   = 1'b0;
        rs_op    = '0;
        rs_ch    = '0;
        have0    = 1'b0;
        d0_hold  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // silence before any midi
        repeat (n_idle * smpl_div) @(negedge clk);

        test_id = 1;
        for (int i = 0; i < n_note; i++) begin
            send_msg(8'h93, 7'(take_bits(7)), 7'(take_bits(7) | 16'd1));
        end

        test_id = 2;
        for (int i = 0; i < n_off; i++) begin
            n = 7'(take_bits(7));
            send_msg(8'h93, n, 7'(take_bits(7) | 16'd1));
            send_msg(8'h83, n + 7'd1, 7'(take_bits(7)));
            send_msg((take_bits(1) != 16'd0) ? 8'h83 : 8'h93, n, 7'd0);
        end

        test_id = 3;
        for (int i = 0; i < n_mixed; i++) begin
            send_mixed();
        end

        test_id = 4;
        for (int i = 0; i < n_pan; i++) begin
            send_msg(8'h93, 7'(take_bits(7)), 7'(take_bits(7) | 16'd1));
            send_msg(8'hb3, 7'd10, 7'(take_bits(7)));
        end

        repeat (6 * smpl_div) @(negedge clk);
        $display("errors: sample=%0d dac=%0d assert=%0d", smpl_errs, dac_errs,
                 u_synth_top.u_synth_checker.assert_fails);
        if (smpl_errs + dac_errs + u_synth_top.u_synth_checker.assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/synth_pkg.sv
rtl/uart_rx.sv
rtl/midi_decoder.sv
rtl/sample_tick_gen.sv
rtl/pulse_voice.sv
rtl/stereo_dac_output.sv
rtl/synth_top.sv
tb/synth_checker.sv
tb/synth_monitor.sv
tb/synth_tb.sv
